//--- Bender.yml
package:
  name: jtag_phy

sources:
  - design/jtag_pkg.sv
  - design/jtag_sync_fifo.sv
  - design/jtag_tap_fsm.sv
  - design/jtag_shift_engine.sv
  - design/jtag_seq_ctrl.sv
  - design/jtag_phy_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_tap_model.sv
      - dv/tb_jtag_phy.sv

//--- all.f
design/jtag_pkg.sv
design/jtag_sync_fifo.sv
design/jtag_tap_fsm.sv
design/jtag_shift_engine.sv
design/jtag_seq_ctrl.sv
design/jtag_phy_top.sv
dv/tb_clk_gen.sv
dv/tb_tap_model.sv
dv/tb_jtag_phy.sv

//--- design/jtag_phy_top.sv
module jtag_phy_top #(
   parameter int BUF_SZ   = jtag_pkg::BUF_SZ,
   parameter int MAX_CLEN = jtag_pkg::MAX_CLEN,
   parameter int FIFO_AW  = 2
) (
   input  logic                 PHY_CLK,
   input  logic                 PHY_CLKn,
   input  logic                 wr_en_i,
   input  jtag_pkg::jtag_cmd_t  wr_data_i,
   output logic                 wr_full_o,
   input  logic                 rd_en_i,
   output jtag_pkg::jtag_resp_t rd_data_o,
   output logic                 rd_empty_o,
   output logic                 tck_o,
   output logic                 tms_o,
   output logic                 tdi_o,
   input  logic                 tdo_i
);

   import jtag_pkg::*;

   // Command layout is fixed by the shared types
   if ($bits(data_t) != BUF_SZ)
      $error("BUF_SZ does not match data_t");
   if ($bits(clen_t) != $clog2(MAX_CLEN))
      $error("MAX_CLEN does not match clen_t");

   jtag_cmd_t  cmd_head;
   logic       cmd_empty;
   logic       cmd_pop;
   jtag_resp_t resp;
   logic       resp_push;
   logic       resp_full;
   tap_state_t tap_state;
   tap_state_t goal;
   logic       step;
   logic       force_tms;
   logic       tms_force_val;
   logic       load;
   logic       shift;
   logic       sample;
   logic       last_bit;
   logic       done;
   data_t      capture;

   jtag_sync_fifo #(.WIDTH($bits(jtag_cmd_t)), .DEPTH_AW(FIFO_AW)) u_cmd_fifo (
      .PHY_CLK   (PHY_CLK),
      .PHY_CLKn  (PHY_CLKn),
      .wr_en_i   (wr_en_i),
      .wr_data_i (wr_data_i),
      .full_o    (wr_full_o),
      .rd_en_i   (cmd_pop),
      .rd_data_o (cmd_head),
      .empty_o   (cmd_empty)
   );

   jtag_sync_fifo #(.WIDTH($bits(jtag_resp_t)), .DEPTH_AW(FIFO_AW)) u_resp_fifo (
      .PHY_CLK   (PHY_CLK),
      .PHY_CLKn  (PHY_CLKn),
      .wr_en_i   (resp_push),
      .wr_data_i (resp),
      .full_o    (resp_full),
      .rd_en_i   (rd_en_i),
      .rd_data_o (rd_data_o),
      .empty_o   (rd_empty_o)
   );

   jtag_seq_ctrl u_seq (
      .PHY_CLK         (PHY_CLK),
      .PHY_CLKn        (PHY_CLKn),
      .cmd_i           (cmd_head),
      .cmd_empty_i     (cmd_empty),
      .cmd_pop_o       (cmd_pop),
      .resp_full_i     (resp_full),
      .resp_push_o     (resp_push),
      .resp_o          (resp),
      .tck_o           (tck_o),
      .step_o          (step),
      .goal_o          (goal),
      .force_tms_o     (force_tms),
      .tms_force_val_o (tms_force_val),
      .load_o          (load),
      .shift_o         (shift),
      .sample_o        (sample),
      .tap_state_i     (tap_state),
      .last_bit_i      (last_bit),
      .done_i          (done),
      .capture_i       (capture)
   );

   jtag_tap_fsm u_tap (
      .PHY_CLK         (PHY_CLK),
      .PHY_CLKn        (PHY_CLKn),
      .step_i          (step),
      .goal_i          (goal),
      .force_tms_i     (force_tms),
      .tms_force_val_i (tms_force_val),
      .state_o         (tap_state),
      .tms_o           (tms_o)
   );

   jtag_shift_engine #(.BUF_SZ(BUF_SZ)) u_shift (
      .PHY_CLK    (PHY_CLK),
      .PHY_CLKn   (PHY_CLKn),
      .load_i     (load),
      .cmd_i      (cmd_head),
      .shift_i    (shift),
      .sample_i   (sample),
      .tdo_i      (tdo_i),
      .tdi_o      (tdi_o),
      .last_bit_o (last_bit),
      .done_o     (done),
      .capture_o  (capture)
   );

endmodule

//--- design/jtag_pkg.sv
package jtag_pkg;

   // Default widths, overridden from the top level
   localparam int BUF_SZ   = 32;
   localparam int MAX_CLEN = 256;
   localparam int CLEN_W   = $clog2(MAX_CLEN);

   // Fixed sequence lengths for the zero-length commands
   localparam int IDLE_TCKS      = 8;
   localparam int RESET_TMS_ONES = 8;

   typedef logic [BUF_SZ-1:0] data_t;
   typedef logic [CLEN_W-1:0] clen_t;

   // Command bits: DR=0/IR=1, msb replication, return captured TDO
   typedef struct packed {
      logic ir_sel;
      logic auto_ext;
      logic capture;
   } jtag_op_t;

   typedef struct packed {
      data_t    data;
      clen_t    len;
      jtag_op_t op;
   } jtag_cmd_t;

   typedef struct packed {
      data_t data;
   } jtag_resp_t;

   // Bits [2:0] walk a 3-bit LFSR, bit 3 picks the IR column
   // state[1] is the TMS value for the natural LFSR step
   typedef enum logic [3:0] {
      RUNTEST_IDLE = 4'b0000,
      LOGIC_RESET  = 4'b1000,
      SELECT_DR    = 4'b0001,
      CAPTURE_DR   = 4'b0100,
      SHIFT_DR     = 4'b0010,
      EXIT1_DR     = 4'b0101,
      PAUSE_DR     = 4'b0110,
      EXIT2_DR     = 4'b0111,
      UPDATE_DR    = 4'b0011,
      SELECT_IR    = 4'b1001,
      CAPTURE_IR   = 4'b1100,
      SHIFT_IR     = 4'b1010,
      EXIT1_IR     = 4'b1101,
      PAUSE_IR     = 4'b1110,
      EXIT2_IR     = 4'b1111,
      UPDATE_IR    = 4'b1011
   } tap_state_t;

endpackage

//--- design/jtag_seq_ctrl.sv
module jtag_seq_ctrl (
   input  logic                 PHY_CLK,
   input  logic                 PHY_CLKn,
   input  jtag_pkg::jtag_cmd_t  cmd_i,
   input  logic                 cmd_empty_i,
   output logic                 cmd_pop_o,
   input  logic                 resp_full_i,
   output logic                 resp_push_o,
   output jtag_pkg::jtag_resp_t resp_o,
   output logic                 tck_o,
   output logic                 step_o,
   output jtag_pkg::tap_state_t goal_o,
   output logic                 force_tms_o,
   output logic                 tms_force_val_o,
   output logic                 load_o,
   output logic                 shift_o,
   output logic                 sample_o,
   input  jtag_pkg::tap_state_t tap_state_i,
   input  logic                 last_bit_i,
   input  logic                 done_i,
   input  jtag_pkg::data_t      capture_i
);

   import jtag_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOAD,
      S_RUN_SHIFT,
      S_RUN_RESET,
      S_RUN_IDLE,
      S_RESPOND
   } seq_state_t;

   seq_state_t st;
   jtag_op_t   op_q;
   clen_t      len_q;
   // TCK steps issued in this command
   clen_t      cnt;
   // Low phase carries the step, high phase the rise
   logic       ph;
   logic       samp_pend;
   logic       is_reset;
   logic       is_idle;
   logic       go_run;
   logic       active;
   logic       rise;
   logic       in_shift;
   logic       can_pop;

   // Zero-length specials, anything else with no length is dropped
   assign is_reset = (len_q == '0) && (op_q == jtag_op_t'(3'b000));
   assign is_idle  = (len_q == '0) && (op_q == jtag_op_t'(3'b110));
   assign go_run   = (len_q != '0) || is_reset || is_idle;

   // LOAD already counts as the first step cycle
   assign active = ((st == S_LOAD) && go_run) || (st == S_RUN_SHIFT) ||
                   (st == S_RUN_RESET) || (st == S_RUN_IDLE);
   assign step_o = active && !ph;
   assign rise   = active && ph;

   assign in_shift = (tap_state_i == SHIFT_DR) || (tap_state_i == SHIFT_IR);
   assign shift_o  = step_o && in_shift && (len_q != '0);
   // TDO of a shifted bit is taken on the following rise
   assign sample_o = rise && samp_pend;

   assign force_tms_o     = step_o && is_reset;
   assign tms_force_val_o = (cnt < clen_t'(RESET_TMS_ONES));

   // Head back to idle with the last bit, so TMS rises with it
   always_comb
   begin
      if ((len_q == '0) || done_i || (last_bit_i && in_shift))
         goal_o = RUNTEST_IDLE;
      else if (op_q.ir_sel)
         goal_o = SHIFT_IR;
      else
         goal_o = SHIFT_DR;
   end

   // A read waits for room in the response FIFO
   assign can_pop   = !cmd_empty_i && (!cmd_i.op.capture || !resp_full_i);
   assign cmd_pop_o = (st == S_IDLE) && can_pop;
   assign load_o    = cmd_pop_o;

   assign resp_push_o = (st == S_RESPOND);
   assign resp_o.data = capture_i;

   always_ff @(posedge PHY_CLK)
   begin
      if (cmd_pop_o)
      begin
         op_q  <= cmd_i.op;
         len_q <= cmd_i.len;
      end
   end

   always_ff @(posedge PHY_CLK or posedge PHY_CLKn)
   begin
      if (PHY_CLKn)
      begin
         st        <= S_IDLE;
         tck_o     <= 1'b0;
         ph        <= 1'b0;
         cnt       <= '0;
         samp_pend <= 1'b0;
      end
      else
      begin
         // TCK is parked low outside a command
         tck_o <= active && ph;
         ph    <= active && !ph;
         if (step_o)
            cnt <= cnt + 1'b1;
         if (shift_o)
            samp_pend <= 1'b1;
         else if (sample_o)
            samp_pend <= 1'b0;

         case (st)
            S_IDLE:
            begin
               if (can_pop)
               begin
                  st  <= S_LOAD;
                  cnt <= '0;
               end
            end
            S_LOAD:
            begin
               if (!go_run)
                  st <= S_IDLE;
               else if (is_reset)
                  st <= S_RUN_RESET;
               else if (is_idle)
                  st <= S_RUN_IDLE;
               else
                  st <= S_RUN_SHIFT;
            end
            S_RUN_SHIFT:
            begin
               // Done once the target has entered RUNTEST_IDLE
               if (rise && done_i && (tap_state_i == RUNTEST_IDLE))
                  st <= op_q.capture ? S_RESPOND : S_IDLE;
            end
            S_RUN_RESET:
            begin
               if (rise && (cnt == clen_t'(RESET_TMS_ONES + 1)))
                  st <= S_IDLE;
            end
            S_RUN_IDLE:
            begin
               if (rise && (cnt == clen_t'(IDLE_TCKS)))
                  st <= S_IDLE;
            end
            default:
               st <= S_IDLE;
         endcase
      end
   end

   // Room was checked at pop time and nothing else pushes
   a_no_push_full: assert property (@(posedge PHY_CLK) disable iff (PHY_CLKn)
      resp_push_o |-> !resp_full_i);

endmodule

//--- design/jtag_shift_engine.sv
module jtag_shift_engine #(
   parameter int BUF_SZ = jtag_pkg::BUF_SZ
) (
   input  logic                PHY_CLK,
   input  logic                PHY_CLKn,
   input  logic                load_i,
   input  jtag_pkg::jtag_cmd_t cmd_i,
   input  logic                shift_i,
   input  logic                sample_i,
   input  logic                tdo_i,
   output logic                tdi_o,
   output logic                last_bit_o,
   output logic                done_o,
   output jtag_pkg::data_t     capture_o
);

   import jtag_pkg::*;

   localparam int IDX_W = $clog2(BUF_SZ);

   data_t sreg;
   clen_t len_q;
   // Bits driven out and bits sampled back
   clen_t cnt;
   clen_t scnt;
   logic  auto_q;

   assign last_bit_o = (len_q != '0) && (cnt == len_q - clen_t'(1));
   assign done_o     = (cnt == len_q);

   always_ff @(posedge PHY_CLK or posedge PHY_CLKn)
   begin
      if (PHY_CLKn)
      begin
         tdi_o  <= 1'b0;
         cnt    <= '0;
         scnt   <= '0;
         len_q  <= '0;
         auto_q <= 1'b0;
      end
      else if (load_i)
      begin
         cnt    <= '0;
         scnt   <= '0;
         len_q  <= cmd_i.len;
         auto_q <= cmd_i.op.auto_ext;
      end
      else
      begin
         if (shift_i)
         begin
            tdi_o <= sreg[0];
            cnt   <= cnt + 1'b1;
         end
         if (sample_i)
            scnt <= scnt + 1'b1;
      end
   end

   always_ff @(posedge PHY_CLK)
   begin
      if (load_i)
      begin
         sreg      <= cmd_i.data;
         capture_o <= '0;
      end
      else
      begin
         // Past the word, msb copies or zeros follow
         if (shift_i)
            sreg <= {auto_q ? sreg[BUF_SZ-1] : 1'b0, sreg[BUF_SZ-1:1]};
         // Only the first word of TDO is kept
         if (sample_i && (scnt < clen_t'(BUF_SZ)))
            capture_o[scnt[IDX_W-1:0]] <= tdo_i;
      end
   end

endmodule

//--- design/jtag_sync_fifo.sv
module jtag_sync_fifo #(
   parameter int WIDTH    = 8,
   parameter int DEPTH_AW = 2
) (
   input  logic             PHY_CLK,
   input  logic             PHY_CLKn,
   input  logic             wr_en_i,
   input  logic [WIDTH-1:0] wr_data_i,
   output logic             full_o,
   input  logic             rd_en_i,
   output logic [WIDTH-1:0] rd_data_o,
   output logic             empty_o
);

   localparam int DEPTH = 2 ** DEPTH_AW;

   logic [WIDTH-1:0]  mem [DEPTH];
   // Extra msb marks a wrap of the pointer
   logic [DEPTH_AW:0] wptr;
   logic [DEPTH_AW:0] rptr;
   logic              push;
   logic              pop;
   // Entries held, modulo the wrap bit
   logic [DEPTH_AW:0] level;

   assign full_o  = (wptr[DEPTH_AW] != rptr[DEPTH_AW]) &&
                    (wptr[DEPTH_AW-1:0] == rptr[DEPTH_AW-1:0]);
   assign empty_o = (wptr == rptr);
   assign level   = wptr - rptr;

   // Blocked accesses are silently dropped
   assign push = wr_en_i && !full_o;
   assign pop  = rd_en_i && !empty_o;

   // Show-ahead head
   assign rd_data_o = mem[rptr[DEPTH_AW-1:0]];

   always_ff @(posedge PHY_CLK)
   begin
      if (push)
      begin
         mem[wptr[DEPTH_AW-1:0]] <= wr_data_i;
      end
   end

   always_ff @(posedge PHY_CLK or posedge PHY_CLKn)
   begin
      if (PHY_CLKn)
      begin
         wptr <= '0;
         rptr <= '0;
      end
      else
      begin
         if (push)
            wptr <= wptr + 1'b1;
         if (pop)
            rptr <= rptr + 1'b1;
      end
   end

   // Write while full never grows the FIFO past its storage
   a_no_push_full: assert property (@(posedge PHY_CLK) disable iff (PHY_CLKn)
      level <= (DEPTH_AW+1)'(DEPTH));

   // Read while empty takes no word that is not there
   a_no_pop_empty: assert property (@(posedge PHY_CLK) disable iff (PHY_CLKn)
      (rd_en_i && empty_o && !wr_en_i) |=> empty_o);

endmodule

//--- design/jtag_tap_fsm.sv
module jtag_tap_fsm (
   input  logic                 PHY_CLK,
   input  logic                 PHY_CLKn,
   input  logic                 step_i,
   input  jtag_pkg::tap_state_t goal_i,
   input  logic                 force_tms_i,
   input  logic                 tms_force_val_i,
   output jtag_pkg::tap_state_t state_o,
   output logic                 tms_o
);

   import jtag_pkg::*;

   // Full IEEE 1149.1 transition, used while TMS is forced
   function automatic tap_state_t tms_next(input tap_state_t s, input logic tms);
      tap_state_t n;
      case (s)
         LOGIC_RESET:              n = tms ? LOGIC_RESET : RUNTEST_IDLE;
         RUNTEST_IDLE:             n = tms ? SELECT_DR : RUNTEST_IDLE;
         SELECT_DR:                n = tms ? SELECT_IR : CAPTURE_DR;
         SELECT_IR:                n = tms ? LOGIC_RESET : CAPTURE_IR;
         CAPTURE_DR, SHIFT_DR:     n = tms ? EXIT1_DR : SHIFT_DR;
         CAPTURE_IR, SHIFT_IR:     n = tms ? EXIT1_IR : SHIFT_IR;
         EXIT1_DR:                 n = tms ? UPDATE_DR : PAUSE_DR;
         EXIT1_IR:                 n = tms ? UPDATE_IR : PAUSE_IR;
         PAUSE_DR:                 n = tms ? EXIT2_DR : PAUSE_DR;
         PAUSE_IR:                 n = tms ? EXIT2_IR : PAUSE_IR;
         EXIT2_DR:                 n = tms ? UPDATE_DR : SHIFT_DR;
         EXIT2_IR:                 n = tms ? UPDATE_IR : SHIFT_IR;
         default:                  n = tms ? SELECT_DR : RUNTEST_IDLE;
      endcase
      return n;
   endfunction

   // TMS and the tracked state move together on each TCK fall
   // state_o is the state the target enters on the next rising TCK
   always_ff @(posedge PHY_CLK or posedge PHY_CLKn)
   begin
      if (PHY_CLKn)
      begin
         state_o <= LOGIC_RESET;
         tms_o   <= 1'b1;
      end
      else if (step_i)
      begin
         if (force_tms_i)
         begin
            tms_o   <= tms_force_val_i;
            state_o <= tms_next(state_o, tms_force_val_i);
         end
         // The two states outside the LFSR cycle
         else if (state_o[2:0] == 3'b000)
         begin
            if (goal_i == state_o)
               tms_o <= state_o[3];
            else if (state_o == LOGIC_RESET)
            begin
               tms_o   <= 1'b0;
               state_o <= RUNTEST_IDLE;
            end
            else
            begin
               tms_o   <= 1'b1;
               state_o <= SELECT_DR;
            end
         end
         // Cross over to the IR column
         else if ((state_o == SELECT_DR) && goal_i[3])
         begin
            tms_o   <= 1'b1;
            state_o <= SELECT_IR;
         end
         else if ((state_o == SELECT_IR) && (goal_i[2:0] == 3'b000))
         begin
            tms_o   <= 1'b1;
            state_o <= LOGIC_RESET;
         end
         // Capture without a shift goes straight to EXIT1
         else if ((state_o[2:0] == 3'b100) && (goal_i[2:0] != 3'b010))
         begin
            tms_o   <= 1'b1;
            state_o <= tap_state_t'({state_o[3], 3'b101});
         end
         else if ((state_o[2:0] == 3'b011) && (goal_i == RUNTEST_IDLE))
         begin
            tms_o   <= 1'b0;
            state_o <= RUNTEST_IDLE;
         end
         // No pause path, EXIT1 always updates
         else if (state_o[2:0] == 3'b101)
         begin
            tms_o   <= 1'b1;
            state_o <= tap_state_t'({state_o[3], 3'b011});
         end
         // Stay in SHIFT-xR
         else if ((state_o[1:0] == 2'b10) && (state_o == goal_i))
            tms_o <= 1'b0;
         // Natural LFSR step, UPDATE returns to the DR column
         else
         begin
            tms_o   <= state_o[1];
            state_o <= tap_state_t'({(state_o[2:0] == 3'b011) ? 1'b0 : state_o[3],
                                     ^state_o[1:0], state_o[2:1]});
         end
      end
   end

   a_no_pause: assert property (@(posedge PHY_CLK) disable iff (PHY_CLKn)
      (state_o != PAUSE_DR) && (state_o != PAUSE_IR));

endmodule

//--- dv/jtag_stim.txt
# cmd = {data[31:0], len[7:0], op[2:0] = ir_sel auto_ext capture} in hex, flag, expected hex
# flag 0 run, 1 TAP state, 2 IR, 3 DR, 4 read word, 5 TCK rises, 6 queue read, 7 drain
00000000000 1 0
0000002d044 2 5a
00000061845 4 5a
00000000006 2 c3
40000000942 3 ff80000001
40000000940 3 0080000001
091a2b3c141 4 80000001
00000000006 3 0012345678
00000000006 5 8
50000000941 6 12345678
58000001141 6 a0000001
60000001941 6 b0000002
68000002141 6 c0000003
70000002941 6 d0000004
78000003141 6 e0000005
00000000000 7 6
00000000006 3 00f0000006

//--- dv/tb_clk_gen.sv
module tb_clk_gen #(
   parameter int PERIOD_NS = 8,
   parameter int RST_CYC   = 3
) (
   output logic clk_o,
   output logic rst_o
);

   timeunit 1ns;
   timeprecision 100ps;

   // Free-running PHY_CLK, starts low
   initial
   begin
      clk_o = 1'b0;
      forever
         #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // Release on a falling edge, away from the stimulus edge
   initial
   begin
      rst_o = 1'b1;
      repeat (RST_CYC)
         @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

//--- dv/tb_jtag_phy.sv
module tb_jtag_phy;

   timeunit 1ns;
   timeprecision 100ps;

   import jtag_pkg::*;

   localparam int FIFO_AW   = 2;
   localparam int TMO_CYC   = 2000;
   // TCK low this long means the sequencer is parked
   localparam int QUIET_CYC = 8;

   logic        PHY_CLK;
   logic        PHY_CLKn;
   logic        wr_en;
   jtag_cmd_t   wr_data;
   logic        wr_full;
   logic        rd_en;
   jtag_resp_t  rd_data;
   logic        rd_empty;
   logic        tck;
   logic        tms;
   logic        tdi;
   logic        tdo;
   tap_state_t  model_state;
   logic [7:0]  model_ir;
   logic [39:0] model_dr;

   // Bus monitor, updated on falling PHY_CLK
   int unsigned tck_rises      = 0;
   int unsigned tms_high_rises = 0;
   int unsigned quiet_cyc      = 0;
   logic        tck_q          = 1'b0;
   logic        full_seen      = 1'b0;

   // Expected words of reads still in flight
   logic [31:0] resp_exp [$];
   int          err_cnt = 0;

   tb_clk_gen u_clk (.clk_o(PHY_CLK), .rst_o(PHY_CLKn));

   jtag_phy_top #(.BUF_SZ(BUF_SZ), .MAX_CLEN(MAX_CLEN), .FIFO_AW(FIFO_AW)) dut0 (
      .PHY_CLK    (PHY_CLK),
      .PHY_CLKn   (PHY_CLKn),
      .wr_en_i    (wr_en),
      .wr_data_i  (wr_data),
      .wr_full_o  (wr_full),
      .rd_en_i    (rd_en),
      .rd_data_o  (rd_data),
      .rd_empty_o (rd_empty),
      .tck_o      (tck),
      .tms_o      (tms),
      .tdi_o      (tdi),
      .tdo_i      (tdo)
   );

   tb_tap_model #(.IR_LEN(8), .DR_LEN(40)) u_target (
      .tck_i   (tck),
      .tms_i   (tms),
      .tdi_i   (tdi),
      .tdo_o   (tdo),
      .state_o (model_state),
      .ir_o    (model_ir),
      .dr_o    (model_dr)
   );

   always @(negedge PHY_CLK)
   begin
      if (tck && !tck_q)
      begin
         tck_rises <= tck_rises + 1;
         if (tms)
            tms_high_rises <= tms_high_rises + 1;
      end
      quiet_cyc <= tck ? 0 : quiet_cyc + 1;
      if (wr_full)
         full_seen <= 1'b1;
      tck_q <= tck;
   end

   task automatic stop_run();
      err_cnt++;
      $display("FAIL: see errors above");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic timeout_if(input int cyc, input string what);
      if (cyc >= TMO_CYC)
      begin
         $display("Timed out after %0d cycles waiting for %s", cyc, what);
         stop_run();
      end
   endtask

   // Inputs move 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge PHY_CLK);
      #1;
   endtask

   task automatic write_cmd(input logic [42:0] cmd);
      int cyc;
      cyc = 0;
      // Random gap before each command
      repeat ($urandom_range(3))
         next_cycle();
      while (wr_full)
      begin
         next_cycle();
         cyc++;
         timeout_if(cyc, "room in the command FIFO");
      end
      wr_en   = 1'b1;
      wr_data = jtag_cmd_t'(cmd);
      next_cycle();
      wr_en   = 1'b0;
   endtask

   // First TCK of the command, then a parked TCK
   task automatic wait_tck_done(input int unsigned start_rises);
      int cyc;
      cyc = 0;
      while (tck_rises == start_rises)
      begin
         next_cycle();
         cyc++;
         timeout_if(cyc, "TCK to start");
      end
      cyc = 0;
      while (quiet_cyc < QUIET_CYC)
      begin
         next_cycle();
         cyc++;
         timeout_if(cyc, "TCK to stop");
      end
   endtask

   task automatic pop_resp(input logic [31:0] exp);
      int cyc;
      cyc = 0;
      while (rd_empty)
      begin
         next_cycle();
         cyc++;
         timeout_if(cyc, "a response word");
      end
      check_val("rd_data_o", rd_data.data, exp);
      rd_en = 1'b1;
      next_cycle();
      rd_en = 1'b0;
   endtask

   // Flags as listed at the top of the stim file
   task automatic run_line(input logic [42:0] cmd, input int flag, input logic [63:0] exp);
      int unsigned rises0;
      int unsigned tms0;
      rises0 = tck_rises;
      tms0   = tms_high_rises;
      if (flag == 4)
      begin
         write_cmd(cmd);
         pop_resp(exp[31:0]);
      end
      else if (flag == 6)
      begin
         write_cmd(cmd);
         resp_exp.push_back(exp[31:0]);
      end
      else if (flag == 7)
      begin
         check_val("queued reads", resp_exp.size(), exp);
         check_val("wr_full_o seen high", full_seen, 1);
         while (resp_exp.size() > 0)
            pop_resp(resp_exp.pop_front());
      end
      else if ((flag >= 0) && (flag <= 5))
      begin
         write_cmd(cmd);
         wait_tck_done(rises0);
         if (flag == 1)
         begin
            check_val("model TAP state", model_state, exp);
            check_val("tms_o", tms, 0);
         end
         else if (flag == 2)
            check_val("model IR", model_ir, exp);
         else if (flag == 3)
            check_val("model DR", model_dr, exp);
         else if (flag == 5)
         begin
            check_val("tck_o rises", tck_rises - rises0, exp);
            check_val("tck_o rises with tms_o high", tms_high_rises - tms0, 0);
            // Nothing queued, so TCK must stay parked
            repeat (20)
               next_cycle();
            check_val("tck_o rises while idle", tck_rises - rises0, exp);
         end
      end
      else
      begin
         $display("Unknown flag %0d in the stim file", flag);
         stop_run();
      end
   endtask

   initial
   begin
      int          fd;
      int          n;
      int          cyc;
      int unsigned seed_draw;
      int          flag;
      string       line;
      logic [63:0] cmd_word;
      logic [63:0] exp_word;
      wr_en     = 1'b0;
      wr_data   = '0;
      rd_en     = 1'b0;
      seed_draw = $urandom(18633);
      cyc       = 0;
      next_cycle();
      while (PHY_CLKn)
      begin
         next_cycle();
         cyc++;
         timeout_if(cyc, "reset release");
      end
      // Idle state straight out of reset
      check_val("wr_full_o", wr_full, 0);
      check_val("rd_empty_o", rd_empty, 1);
      check_val("tck_o", tck, 0);
      check_val("tms_o", tms, 1);
      fd = $fopen("dv/jtag_stim.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open dv/jtag_stim.txt for reading");
         stop_run();
      end
      while (!$feof(fd))
      begin
         n = $fgets(line, fd);
         // Header and blank lines do not scan as three fields
         if ((n > 0) && ($sscanf(line, "%h %d %h", cmd_word, flag, exp_word) == 3))
            run_line(cmd_word[42:0], flag, exp_word);
      end
      $fclose(fd);
      if (err_cnt == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- dv/tb_tap_model.sv
module tb_tap_model #(
   parameter int IR_LEN = 8,
   parameter int DR_LEN = 40
) (
   input  logic                 tck_i,
   input  logic                 tms_i,
   input  logic                 tdi_i,
   output logic                 tdo_o,
   output jtag_pkg::tap_state_t state_o,
   output logic [IR_LEN-1:0]    ir_o,
   output logic [DR_LEN-1:0]    dr_o
);

   timeunit 1ns;
   timeprecision 100ps;

   import jtag_pkg::*;

   // IEEE 1149.1 state diagram of the target
   function automatic tap_state_t tap_next_state(input tap_state_t s, input logic tms);
      case (s)
         LOGIC_RESET:  return tms ? LOGIC_RESET : RUNTEST_IDLE;
         RUNTEST_IDLE: return tms ? SELECT_DR : RUNTEST_IDLE;
         SELECT_DR:    return tms ? SELECT_IR : CAPTURE_DR;
         CAPTURE_DR:   return tms ? EXIT1_DR : SHIFT_DR;
         SHIFT_DR:     return tms ? EXIT1_DR : SHIFT_DR;
         EXIT1_DR:     return tms ? UPDATE_DR : PAUSE_DR;
         PAUSE_DR:     return tms ? EXIT2_DR : PAUSE_DR;
         EXIT2_DR:     return tms ? UPDATE_DR : SHIFT_DR;
         UPDATE_DR:    return tms ? SELECT_DR : RUNTEST_IDLE;
         SELECT_IR:    return tms ? LOGIC_RESET : CAPTURE_IR;
         CAPTURE_IR:   return tms ? EXIT1_IR : SHIFT_IR;
         SHIFT_IR:     return tms ? EXIT1_IR : SHIFT_IR;
         EXIT1_IR:     return tms ? UPDATE_IR : PAUSE_IR;
         PAUSE_IR:     return tms ? EXIT2_IR : PAUSE_IR;
         EXIT2_IR:     return tms ? UPDATE_IR : SHIFT_IR;
         default:      return tms ? SELECT_DR : RUNTEST_IDLE;
      endcase
   endfunction

   // Power-up contents, IR starts at an IDCODE-like value
   initial
   begin
      state_o = LOGIC_RESET;
      ir_o    = 8'h01;
      dr_o    = '0;
      tdo_o   = 1'b0;
   end

   // TMS and TDI taken on rising TCK, lsb leaves first
   // No capture load, a shift returns what was there before
   always @(posedge tck_i)
   begin
      if (state_o == SHIFT_IR)
         ir_o <= {tdi_i, ir_o[IR_LEN-1:1]};
      else if (state_o == SHIFT_DR)
         dr_o <= {tdi_i, dr_o[DR_LEN-1:1]};
      state_o <= tap_next_state(state_o, tms_i);
   end

   // TDO changes on falling TCK
   always @(negedge tck_i)
   begin
      if (state_o == SHIFT_IR)
         tdo_o <= ir_o[0];
      else if (state_o == SHIFT_DR)
         tdo_o <= dr_o[0];
      else
         tdo_o <= 1'b0;
   end

endmodule
